// File: iadc_reg_pkg.sv
package iadc_reg_pkg;

  localparam int WB_DATA_W = 16;
  localparam int WB_SEL_W  = WB_DATA_W / 8;
  localparam int WB_ADR_W  = 32;
  localparam int REG_IDX_W = 4;  // word offset taken from wb_adr_i[4:1]

  typedef logic [WB_DATA_W-1:0] wb_data_t;
  typedef logic [WB_SEL_W-1:0]  wb_sel_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // register map, one 16-bit word per index
  localparam reg_idx_t REG_RESET       = 4'd0;   // write 1 pulses adc_ddrb
  localparam reg_idx_t REG_MODE        = 4'd1;   // interleave mode pin
  localparam reg_idx_t REG_TWI_ADDR    = 4'd2;
  localparam reg_idx_t REG_TWI_DATA    = 4'd3;
  localparam reg_idx_t REG_TWI_TX      = 4'd4;   // write starts, read gives busy
  localparam reg_idx_t REG_FIFODATA_4  = 4'd5;   // sync and out-of-range bits
  localparam reg_idx_t REG_FIFODATA_3  = 4'd6;
  localparam reg_idx_t REG_FIFODATA_2  = 4'd7;
  localparam reg_idx_t REG_FIFODATA_1  = 4'd8;
  localparam reg_idx_t REG_FIFODATA_0  = 4'd9;
  localparam reg_idx_t REG_FIFO_ADV    = 4'd10;  // write 1 pops the head entry
  localparam reg_idx_t REG_FIFO_STATUS = 4'd11;
  localparam reg_idx_t REG_FIFO_CTRL   = 4'd12;  // bit 0 enables capture

endpackage

// File: iadc_adc_pkg.sv
package iadc_adc_pkg;

  // sample layout: 2 channels x 4 interleaved phases x 8 bits
  localparam int ADC_DATA_W = 64;
  localparam int ADC_OOR_W  = 4;
  localparam int SAMPLE_W   = 1 + ADC_OOR_W + ADC_DATA_W;

  typedef logic [SAMPLE_W-1:0] sample_t;  // {sync, outofrange, data}

  // sample fifo
  localparam int FIFO_DEPTH_LOG2 = 4;
  localparam int FIFO_DEPTH      = 1 << FIFO_DEPTH_LOG2;
  localparam int FIFO_ALMOST     = 2;  // fill distance for the almost flags

  typedef logic [FIFO_DEPTH_LOG2:0] fifo_ptr_t;  // extra msb tells full from empty
  typedef logic [3:0] fifo_status_t;             // {full, almost_full, almost_empty, empty}

  // three-wire configuration port
  localparam int TWI_DIV_LOG2 = 3;  // serial clock period of 8 wb clocks
  localparam int TWI_ADDR_W   = 3;
  localparam int TWI_DATA_W   = 16;
  localparam int TWI_BITS     = TWI_ADDR_W + TWI_DATA_W;

  typedef logic [TWI_ADDR_W-1:0] twi_addr_t;
  typedef logic [TWI_BITS-1:0]   twi_word_t;  // address above data

  typedef enum logic [2:0] {
    IDLE   = 3'd0,  // nothing to send
    WAIT   = 3'd1,  // line up with the divider
    STRB0  = 3'd2,  // one clock with strobe inactive
    DATA   = 3'd3,  // address and data bits, msb first
    COMMIT = 3'd4,  // commit clock with strobe still low
    STRB1  = 3'd5,
    SWAIT  = 3'd6
  } twi_state_e;

endpackage

// File: iadc_fifo_rd_if.sv
`timescale 1ns/1ps

interface iadc_fifo_rd_if;
  import iadc_adc_pkg::*;

  logic         rd_en;    // pop head entry, ignored when empty
  logic         flush;    // discard everything queued
  logic         enable;   // capture level
  sample_t      rd_data;  // head entry
  fifo_status_t status;

  modport regs (
    output rd_en, flush, enable,
    input  rd_data, status
  );

  modport fifo (
    input  rd_en, flush, enable,
    output rd_data, status
  );

endinterface

// File: iadc_wb_regs.sv
`timescale 1ns/1ps

module iadc_wb_regs (
  input  logic                              wb_clk_i,
  input  logic                              wb_rst_i,
  input  logic                              wb_cyc_i,
  input  logic                              wb_stb_i,
  input  logic                              wb_we_i,
  input  iadc_reg_pkg::wb_sel_t             wb_sel_i,
  input  logic [iadc_reg_pkg::WB_ADR_W-1:0] wb_adr_i,
  input  iadc_reg_pkg::wb_data_t            wb_dat_i,
  output iadc_reg_pkg::wb_data_t            wb_dat_o,
  output logic                              wb_ack_o,
  output iadc_adc_pkg::twi_word_t           twi_word_o,
  output logic                              tx_start_o,
  input  logic                              twi_busy_i,
  output logic                              adc_mode_o,
  output logic                              adc_ddrb_o,
  iadc_fifo_rd_if.regs                      fifo
);
  import iadc_reg_pkg::*;
  import iadc_adc_pkg::*;

  logic      wb_req;
  reg_idx_t  req_idx;
  reg_idx_t  rd_src_q;     // index of the access being acked
  twi_addr_t twi_addr_q;
  wb_data_t  twi_data_q;
  logic      tx_req_q;
  logic      rd_en_q;
  logic      enable_q;
  logic      enable_d1_q;

  assign wb_req  = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // ack low forces a gap cycle
  assign req_idx = wb_adr_i[REG_IDX_W:1];

  always_ff @(posedge wb_clk_i) begin
    wb_ack_o   <= 1'b0;
    adc_ddrb_o <= 1'b0;
    tx_req_q   <= 1'b0;
    rd_en_q    <= 1'b0;
    if (wb_rst_i) begin
      adc_mode_o <= 1'b0;
      twi_addr_q <= '0;
      twi_data_q <= '0;
      enable_q   <= 1'b0;
      rd_src_q   <= REG_RESET;
    end else if (wb_req) begin
      wb_ack_o <= 1'b1;
      rd_src_q <= req_idx;
      if (wb_we_i) begin
        case (req_idx)
          REG_RESET:     if (wb_sel_i[0]) adc_ddrb_o <= wb_dat_i[0];
          REG_MODE:      if (wb_sel_i[0]) adc_mode_o <= wb_dat_i[0];
          REG_TWI_ADDR:  if (wb_sel_i[0]) twi_addr_q <= wb_dat_i[TWI_ADDR_W-1:0];
          REG_TWI_DATA: begin
            if (wb_sel_i[1])
              twi_data_q[15:8] <= wb_dat_i[15:8];
            if (wb_sel_i[0])
              twi_data_q[7:0] <= wb_dat_i[7:0];
          end
          REG_TWI_TX:    if (wb_sel_i[0]) tx_req_q <= 1'b1;  // data value ignored
          REG_FIFO_ADV:  if (wb_sel_i[0]) rd_en_q <= wb_dat_i[0];
          REG_FIFO_CTRL: if (wb_sel_i[0]) enable_q <= wb_dat_i[0];
          default: ;  // read-only or unmapped
        endcase
      end
    end
  end

  // start goes out the cycle after ack, enable edge makes the flush
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      tx_start_o  <= 1'b0;
      enable_d1_q <= 1'b0;
    end else begin
      tx_start_o  <= tx_req_q;
      enable_d1_q <= enable_q;
    end
  end

  assign twi_word_o  = {twi_addr_q, twi_data_q};
  assign fifo.rd_en  = rd_en_q;
  assign fifo.enable = enable_q;
  assign fifo.flush  = enable_q & ~enable_d1_q;

  always_comb begin
    case (rd_src_q)
      REG_RESET:       wb_dat_o = wb_data_t'(adc_ddrb_o);
      REG_MODE:        wb_dat_o = wb_data_t'(adc_mode_o);
      REG_TWI_ADDR:    wb_dat_o = wb_data_t'(twi_addr_q);
      REG_TWI_DATA:    wb_dat_o = twi_data_q;
      REG_TWI_TX:      wb_dat_o = wb_data_t'(twi_busy_i);
      REG_FIFODATA_4:  wb_dat_o = wb_data_t'(fifo.rd_data[SAMPLE_W-1:ADC_DATA_W]);
      REG_FIFODATA_3:  wb_dat_o = fifo.rd_data[63:48];
      REG_FIFODATA_2:  wb_dat_o = fifo.rd_data[47:32];
      REG_FIFODATA_1:  wb_dat_o = fifo.rd_data[31:16];
      REG_FIFODATA_0:  wb_dat_o = fifo.rd_data[15:0];
      REG_FIFO_STATUS: wb_dat_o = wb_data_t'(fifo.status);
      REG_FIFO_CTRL:   wb_dat_o = wb_data_t'(enable_q);
      default:         wb_dat_o = '0;
    endcase
  end

  // every accepted cycle is separated by at least one idle cycle
  a_ack_single: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    wb_ack_o |=> !wb_ack_o);

endmodule

// File: iadc_twi_shifter.sv
`timescale 1ns/1ps

module iadc_twi_shifter (
  input  logic                    wb_clk_i,
  input  logic                    wb_rst_i,
  input  iadc_adc_pkg::twi_word_t twi_word_i,
  input  logic                    tx_start_i,
  output logic                    busy_o,
  output logic                    adc_ctrl_clk_o,
  output logic                    adc_ctrl_data_o,
  output logic                    adc_ctrl_strobe_n_o
);
  import iadc_adc_pkg::*;

  logic [TWI_DIV_LOG2-1:0]     div_q;
  logic                        div_wrap;
  logic                        load;
  twi_state_e                  state_q;
  twi_word_t                   shift_q;
  logic [$clog2(TWI_BITS)-1:0] bit_cnt_q;

  assign div_wrap = &div_q;                         // serial clock falls here
  assign load     = tx_start_i && (state_q == IDLE);  // a start while busy is lost

  // free running, so the first edge lands anywhere in the period
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i)
      div_q <= '0;
    else
      div_q <= div_q + 1'b1;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      state_q   <= IDLE;
      shift_q   <= '0;
      bit_cnt_q <= '0;
    end else if (load) begin
      state_q   <= WAIT;
      shift_q   <= twi_word_i;
      bit_cnt_q <= '0;
    end else if (div_wrap) begin
      case (state_q)
        WAIT:   state_q <= STRB0;
        STRB0:  state_q <= DATA;
        DATA: begin
          shift_q   <= {shift_q[TWI_BITS-2:0], 1'b0};
          bit_cnt_q <= bit_cnt_q + 1'b1;
          if (int'(bit_cnt_q) == TWI_BITS - 1)
            state_q <= COMMIT;
        end
        COMMIT: state_q <= STRB1;
        STRB1:  state_q <= SWAIT;
        SWAIT:  state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  assign busy_o              = (state_q != IDLE);
  assign adc_ctrl_clk_o      = (state_q == IDLE || state_q == WAIT) ? 1'b0
                                                                    : div_q[TWI_DIV_LOG2-1];
  assign adc_ctrl_strobe_n_o = !(state_q == DATA || state_q == COMMIT);
  assign adc_ctrl_data_o     = shift_q[TWI_BITS-1];  // msb first

  // the word only moves while bits are being clocked out
  a_shift_in_data: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (!load && state_q != DATA) |=> $stable(shift_q));

endmodule

// File: iadc_capture_fifo.sv
`timescale 1ns/1ps

module iadc_capture_fifo (
  input  logic                                wb_clk_i,
  input  logic                                wb_rst_i,
  input  logic                                adc_clk_i,
  input  logic [iadc_adc_pkg::ADC_DATA_W-1:0] adc_data_i,
  input  logic [iadc_adc_pkg::ADC_OOR_W-1:0]  adc_outofrange_i,
  input  logic                                adc_sync_i,
  iadc_fifo_rd_if.fifo                        rd
);
  import iadc_adc_pkg::*;

  function automatic fifo_ptr_t bin2gray(input fifo_ptr_t b);
    return b ^ (b >> 1);
  endfunction

  function automatic fifo_ptr_t gray2bin(input fifo_ptr_t g);
    fifo_ptr_t b;
    b[FIFO_DEPTH_LOG2] = g[FIFO_DEPTH_LOG2];
    for (int i = FIFO_DEPTH_LOG2 - 1; i >= 0; i--)
      b[i] = b[i+1] ^ g[i];
    return b;
  endfunction

  sample_t   mem [FIFO_DEPTH];

  // adc clock domain
  logic      adc_rst_meta_q;
  logic      adc_rst_q;
  logic      en_meta_q;
  logic      en_q;
  sample_t   sample_q;
  fifo_ptr_t wr_bin_q;
  fifo_ptr_t wr_gray_q;
  fifo_ptr_t wr_bin_next;
  fifo_ptr_t rd_gray_meta_q;
  fifo_ptr_t rd_gray_sync_q;
  fifo_ptr_t wr_level;   // pessimistic, read side seen late
  logic      wr_en;

  // wishbone clock domain
  fifo_ptr_t rd_bin_q;
  fifo_ptr_t rd_gray_q;
  fifo_ptr_t rd_bin_next;
  fifo_ptr_t wr_gray_meta_q;
  fifo_ptr_t wr_gray_sync_q;
  fifo_ptr_t wr_bin_sync;
  fifo_ptr_t rd_level;
  logic      empty;

  always_ff @(posedge adc_clk_i) begin
    adc_rst_meta_q <= wb_rst_i;
    adc_rst_q      <= adc_rst_meta_q;
    sample_q       <= {adc_sync_i, adc_outofrange_i, adc_data_i};
  end

  always_ff @(posedge adc_clk_i) begin
    if (adc_rst_q) begin
      en_meta_q      <= 1'b0;
      en_q           <= 1'b0;
      rd_gray_meta_q <= '0;
      rd_gray_sync_q <= '0;
      wr_bin_q       <= '0;
      wr_gray_q      <= '0;
    end else begin
      en_meta_q      <= rd.enable;
      en_q           <= en_meta_q;
      rd_gray_meta_q <= rd_gray_q;
      rd_gray_sync_q <= rd_gray_meta_q;
      wr_bin_q       <= wr_bin_next;
      wr_gray_q      <= bin2gray(wr_bin_next);
    end
  end

  assign wr_level    = wr_bin_q - gray2bin(rd_gray_sync_q);
  assign wr_en       = en_q && (wr_level != fifo_ptr_t'(FIFO_DEPTH));  // full drops samples
  assign wr_bin_next = wr_en ? wr_bin_q + 1'b1 : wr_bin_q;

  always_ff @(posedge adc_clk_i) begin
    if (wr_en)
      mem[wr_bin_q[FIFO_DEPTH_LOG2-1:0]] <= sample_q;
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      wr_gray_meta_q <= '0;
      wr_gray_sync_q <= '0;
      rd_bin_q       <= '0;
      rd_gray_q      <= '0;
    end else begin
      wr_gray_meta_q <= wr_gray_q;
      wr_gray_sync_q <= wr_gray_meta_q;
      rd_bin_q       <= rd_bin_next;
      rd_gray_q      <= bin2gray(rd_bin_next);
    end
  end

  assign wr_bin_sync = gray2bin(wr_gray_sync_q);
  assign rd_level    = wr_bin_sync - rd_bin_q;
  assign empty       = (rd_level == '0);

  always_comb begin
    rd_bin_next = rd_bin_q;
    if (rd.flush)
      rd_bin_next = wr_bin_sync;  // skip whatever is left from the last run
    else if (rd.rd_en && !empty)
      rd_bin_next = rd_bin_q + 1'b1;
  end

  assign rd.rd_data = mem[rd_bin_q[FIFO_DEPTH_LOG2-1:0]];
  assign rd.status  = {rd_level == fifo_ptr_t'(FIFO_DEPTH),
                       rd_level >= fifo_ptr_t'(FIFO_DEPTH - FIFO_ALMOST),
                       rd_level <= fifo_ptr_t'(FIFO_ALMOST),
                       empty};

  a_no_write_full: assert property (@(posedge adc_clk_i) disable iff (adc_rst_q)
    (wr_level == fifo_ptr_t'(FIFO_DEPTH)) |=> (wr_bin_q == $past(wr_bin_q)));

  a_no_read_empty: assert property (@(posedge wb_clk_i) disable iff (wb_rst_i)
    (empty && !rd.flush) |=> (rd_bin_q == $past(rd_bin_q)));

endmodule

// File: iadc_controller.sv
`timescale 1ns/1ps

module iadc_controller (
  input  logic        wb_clk_i,
  input  logic        wb_rst_i,
  input  logic        wb_cyc_i,
  input  logic        wb_stb_i,
  input  logic        wb_we_i,
  input  logic [1:0]  wb_sel_i,
  input  logic [31:0] wb_adr_i,
  input  logic [15:0] wb_dat_i,
  output logic [15:0] wb_dat_o,
  output logic        wb_ack_o,
  input  logic        adc_clk_i,
  input  logic [63:0] adc_data_i,       // {ch1 phases 3..0, ch0 phases 3..0}
  input  logic        adc_sync_i,
  input  logic [3:0]  adc_outofrange_i,
  output logic        adc_ctrl_clk_o,
  output logic        adc_ctrl_data_o,
  output logic        adc_ctrl_strobe_n_o,
  output logic        adc_mode_o,        // interleave mode select
  output logic        adc_ddrb_o
);
  import iadc_adc_pkg::*;

  twi_word_t twi_word;
  logic      tx_start;
  logic      twi_busy;

  iadc_fifo_rd_if fifo_rd ();

  iadc_wb_regs u_regs (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wb_cyc_i   (wb_cyc_i),
    .wb_stb_i   (wb_stb_i),
    .wb_we_i    (wb_we_i),
    .wb_sel_i   (wb_sel_i),
    .wb_adr_i   (wb_adr_i),
    .wb_dat_i   (wb_dat_i),
    .wb_dat_o   (wb_dat_o),
    .wb_ack_o   (wb_ack_o),
    .twi_word_o (twi_word),
    .tx_start_o (tx_start),
    .twi_busy_i (twi_busy),
    .adc_mode_o (adc_mode_o),
    .adc_ddrb_o (adc_ddrb_o),
    .fifo       (fifo_rd)
  );

  iadc_twi_shifter u_twi (
    .wb_clk_i            (wb_clk_i),
    .wb_rst_i            (wb_rst_i),
    .twi_word_i          (twi_word),
    .tx_start_i          (tx_start),
    .busy_o              (twi_busy),
    .adc_ctrl_clk_o      (adc_ctrl_clk_o),
    .adc_ctrl_data_o     (adc_ctrl_data_o),
    .adc_ctrl_strobe_n_o (adc_ctrl_strobe_n_o)
  );

  iadc_capture_fifo u_fifo (
    .wb_clk_i         (wb_clk_i),
    .wb_rst_i         (wb_rst_i),
    .adc_clk_i        (adc_clk_i),
    .adc_data_i       (adc_data_i),
    .adc_outofrange_i (adc_outofrange_i),
    .adc_sync_i       (adc_sync_i),
    .rd               (fifo_rd)
  );

endmodule

// File: tb_iadc_controller.sv
`timescale 1ns/1ps

module tb_iadc_controller;
  import iadc_reg_pkg::*;
  import iadc_adc_pkg::*;

  localparam int TWI_CYCLES      = (TWI_BITS + 6) << TWI_DIV_LOG2;  // one transfer plus alignment
  localparam int DRAIN_CYCLES    = FIFO_DEPTH * 16;                 // 8 accesses per sample
  localparam int WATCHDOG_CYCLES = 4 * (3 * TWI_CYCLES + 4 * DRAIN_CYCLES + 400);

  logic        wb_clk_i;
  logic        wb_rst_i;
  logic        wb_cyc_i;
  logic        wb_stb_i;
  logic        wb_we_i;
  logic [1:0]  wb_sel_i;
  logic [31:0] wb_adr_i;
  logic [15:0] wb_dat_i;
  logic [15:0] wb_dat_o;
  logic        wb_ack_o;
  logic        adc_clk_i;
  logic [63:0] adc_data_i;
  logic        adc_sync_i;
  logic [3:0]  adc_outofrange_i;
  logic        adc_ctrl_clk_o;
  logic        adc_ctrl_data_o;
  logic        adc_ctrl_strobe_n_o;
  logic        adc_mode_o;
  logic        adc_ddrb_o;

  logic [15:0] adc_cnt;
  logic [31:0] rx_word;
  int          rx_bits;
  int          ddrb_cycles;
  string       test_name;

  iadc_controller UUT (.*);

  always #20 wb_clk_i = ~wb_clk_i;
  always #14 adc_clk_i = ~adc_clk_i;

  function automatic logic [3:0] oor_of(input logic [15:0] c);
    return c[3:0] ^ c[11:8];
  endfunction

  function automatic logic sync_of(input logic [15:0] c);
    return c[4:0] == 5'd0;  // one sync per 32 samples
  endfunction

  function automatic sample_t sample_of(input logic [15:0] c);
    return {sync_of(c), oor_of(c), {4{c}}};
  endfunction

  function automatic sample_t next_sample(input sample_t s);
    return sample_of(s[15:0] + 16'd1);
  endfunction

  function automatic twi_word_t twi_expect(input twi_addr_t a, input logic [15:0] d);
    return {a, d};  // address goes out first
  endfunction

  // adc pins change on the falling adc edge
  always @(negedge adc_clk_i) begin
    adc_cnt          = adc_cnt + 16'd1;
    adc_data_i       = {4{adc_cnt}};
    adc_outofrange_i = oor_of(adc_cnt);
    adc_sync_i       = sync_of(adc_cnt);
  end

  always @(posedge adc_ctrl_clk_o) begin
    if (!adc_ctrl_strobe_n_o) begin
      rx_word = {rx_word[30:0], adc_ctrl_data_o};
      rx_bits = rx_bits + 1;
    end
  end

  always @(negedge wb_clk_i) begin
    if (adc_ddrb_o)
      ddrb_cycles = ddrb_cycles + 1;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string what, input logic [71:0] exp, input logic [71:0] act);
    if (exp !== act)
      abort_run($sformatf("Error: [%s] %s expected %h actual %h", test_name, what, exp, act));
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge wb_clk_i);
    abort_run("watchdog expired, the run did not finish in time");
  end

  task automatic wb_access(input reg_idx_t idx, input logic we, input wb_data_t wdat,
                           input wb_sel_t sel, output wb_data_t rdat);
    @(negedge wb_clk_i);
    check_equal("ack low before strobe", 0, wb_ack_o);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_sel_i = sel;
    wb_adr_i = {27'd0, idx, 1'b0};
    wb_dat_i = wdat;
    @(negedge wb_clk_i);
    check_equal("ack one cycle after strobe", 1, wb_ack_o);
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
  endtask

  task automatic wb_write(input reg_idx_t idx, input wb_data_t wdat, input wb_sel_t sel);
    wb_data_t unused;
    wb_access(idx, 1'b1, wdat, sel, unused);
  endtask

  task automatic wb_read(input reg_idx_t idx, output wb_data_t rdat);
    wb_access(idx, 1'b0, 16'h0000, 2'b11, rdat);
  endtask

  task automatic wait_status(input int bit_pos, input logic val);
    wb_data_t st;
    for (int i = 0; i < 64; i++) begin
      wb_read(REG_FIFO_STATUS, st);
      if (st[bit_pos] == val)
        return;
    end
    abort_run($sformatf("FIFO status bit %0d never reached %0b", bit_pos, val));
  endtask

  task automatic wait_twi_idle();
    wb_data_t busy;
    for (int i = 0; i < TWI_CYCLES; i++) begin
      wb_read(REG_TWI_TX, busy);
      if (busy == 16'h0000)
        return;
    end
    abort_run("serial port stayed busy past its longest transfer");
  endtask

  task automatic set_capture(input logic on);
    wb_write(REG_FIFO_CTRL, {15'd0, on}, 2'b01);
    if (!on)
      repeat (10) @(negedge wb_clk_i);  // enable and pointer synchronizers settle
  endtask

  task automatic read_sample(output sample_t s);
    wb_data_t d;
    wb_read(REG_FIFODATA_4, d);
    check_equal("fifodata_4 upper bits", 0, d[WB_DATA_W-1:SAMPLE_W-ADC_DATA_W]);
    s[SAMPLE_W-1:ADC_DATA_W] = d[SAMPLE_W-ADC_DATA_W-1:0];
    wb_read(REG_FIFODATA_3, d);
    s[63:48] = d;
    wb_read(REG_FIFODATA_2, d);
    s[47:32] = d;
    wb_read(REG_FIFODATA_1, d);
    s[31:16] = d;
    wb_read(REG_FIFODATA_0, d);
    s[15:0] = d;
  endtask

  // pops until empty and checks each sample against the one before it
  task automatic drain_fifo(input int expect_n);
    wb_data_t st;
    sample_t  s;
    sample_t  prev;
    int       n;
    n = 0;
    wb_read(REG_FIFO_STATUS, st);
    while (!st[0]) begin
      if (n >= FIFO_DEPTH)
        abort_run("FIFO returned more entries than its depth");
      read_sample(s);
      if (n > 0)
        check_equal("consecutive sample", next_sample(prev), s);
      prev = s;
      n++;
      wb_write(REG_FIFO_ADV, 16'h0001, 2'b01);
      wb_read(REG_FIFO_STATUS, st);
    end
    if (expect_n > 0)
      check_equal("samples drained", expect_n, n);
    else
      check_equal("samples drained nonzero", 1, n > 0);
    check_equal("status after drain", 4'h3, st[3:0]);
  endtask

  initial begin
    wb_data_t    rd;
    twi_addr_t   t_addr;
    logic [15:0] t_data;
    void'($urandom(32'h8d5c));
    wb_clk_i         = 1'b0;
    adc_clk_i        = 1'b0;
    wb_rst_i         = 1'b1;
    wb_cyc_i         = 1'b0;
    wb_stb_i         = 1'b0;
    wb_we_i          = 1'b0;
    wb_sel_i         = 2'b00;
    wb_adr_i         = '0;
    wb_dat_i         = '0;
    adc_cnt          = 16'hfff0;  // crosses the counter wrap early on
    adc_data_i       = {4{adc_cnt}};
    adc_outofrange_i = oor_of(adc_cnt);
    adc_sync_i       = sync_of(adc_cnt);
    rx_word          = '0;
    rx_bits          = 0;
    ddrb_cycles      = 0;
    repeat (10) @(negedge wb_clk_i);
    wb_rst_i = 1'b0;

    test_name = "reset state";
    check_equal("adc_mode_o", 0, adc_mode_o);
    check_equal("adc_ddrb_o", 0, adc_ddrb_o);
    check_equal("adc_ctrl_clk_o", 0, adc_ctrl_clk_o);
    check_equal("adc_ctrl_strobe_n_o", 1, adc_ctrl_strobe_n_o);
    wb_read(REG_FIFO_STATUS, rd);
    check_equal("fifo status", 16'h0003, rd);
    wb_read(REG_FIFO_CTRL, rd);
    check_equal("capture enable", 16'h0000, rd);

    test_name = "register readback";
    wb_write(REG_MODE, 16'h0001, 2'b01);
    wb_write(REG_MODE, 16'h0000, 2'b10);  // byte 0 not selected so mode holds
    wb_read(REG_MODE, rd);
    check_equal("mode", 16'h0001, rd);
    check_equal("adc_mode_o pin", 1, adc_mode_o);
    wb_write(REG_TWI_ADDR, 16'h0005, 2'b01);
    wb_read(REG_TWI_ADDR, rd);
    check_equal("serial address", 16'h0005, rd);
    wb_write(REG_TWI_DATA, 16'ha55a, 2'b11);
    wb_write(REG_TWI_DATA, 16'h1234, 2'b01);
    wb_write(REG_TWI_DATA, 16'h7700, 2'b10);
    wb_read(REG_TWI_DATA, rd);
    check_equal("serial data", 16'h7734, rd);
    for (int i = 13; i < 16; i++) begin
      wb_read(reg_idx_t'(i), rd);
      check_equal("unused index", 16'h0000, rd);
    end

    test_name = "reset pulse";
    wb_write(REG_RESET, 16'h0001, 2'b01);
    repeat (4) @(negedge wb_clk_i);
    check_equal("adc_ddrb_o high cycles", 1, ddrb_cycles);

    test_name = "serial transfer";
    for (int t = 0; t < 3; t++) begin
      t_addr = twi_addr_t'($urandom);
      t_data = 16'($urandom);
      wb_write(REG_TWI_ADDR, wb_data_t'(t_addr), 2'b01);
      wb_write(REG_TWI_DATA, t_data, 2'b11);
      rx_word = '0;
      rx_bits = 0;
      wb_write(REG_TWI_TX, 16'h0001, 2'b01);
      wb_read(REG_TWI_TX, rd);
      check_equal("busy during transfer", 16'h0001, rd);
      wait_twi_idle();
      check_equal("clocks with strobe low", TWI_BITS + 1, rx_bits);  // bits plus commit
      check_equal("serial word", twi_expect(t_addr, t_data), rx_word[TWI_BITS:1]);
      repeat ($urandom_range(1, 8)) @(negedge wb_clk_i);
    end

    test_name = "capture stream";
    set_capture(1'b1);
    wait_status(0, 1'b0);
    set_capture(1'b0);
    drain_fifo(0);

    test_name = "full fifo";
    set_capture(1'b1);
    wait_status(3, 1'b1);
    set_capture(1'b0);
    wb_read(REG_FIFO_STATUS, rd);
    check_equal("status when full", 16'h000c, rd);
    drain_fifo(FIFO_DEPTH);

    test_name = "flush on re-enable";
    set_capture(1'b1);
    wait_status(3, 1'b1);
    set_capture(1'b0);
    set_capture(1'b1);
    wb_read(REG_FIFO_STATUS, rd);
    check_equal("full flag after flush", 0, rd[3]);
    wait_status(0, 1'b0);
    set_capture(1'b0);
    drain_fifo(0);

    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: sources.f
iadc_reg_pkg.sv
iadc_adc_pkg.sv
iadc_fifo_rd_if.sv
iadc_wb_regs.sv
iadc_twi_shifter.sv
iadc_capture_fifo.sv
iadc_controller.sv
tb_iadc_controller.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_iadc_controller \
  -f sources.f \
  -o sim_iadc_controller

./obj_dir/sim_iadc_controller
